//--- flist.f
design/mips_pkg.sv
design/fetch_unit.sv
design/stage_regs.sv
design/decoder.sv
design/reg_file.sv
design/hazard_unit.sv
design/alu.sv
design/mips_core.sv
bench/mips_checker.sv
bench/mips_props.sv
bench/tb_mips.sv

//--- run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mips -f flist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_mips)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1

//--- bench/tb_mips.sv
`timescale 1ns/1ps

module tb_mips;

	localparam int prog_len   = 200;
	localparam int dmem_words = 64;
	localparam int max_cycles = 3000;

	logic        clk;
	logic        reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_rdata;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_we;
	logic [31:0] dmem_rdata;
	logic        reg_we;
	logic [4:0]  reg_waddr;
	logic [31:0] reg_wdata;
	logic [31:0] wb_pc;

	logic [31:0] prog [prog_len];
	logic [31:0] dmem_init [dmem_words];
	logic [31:0] dmem [dmem_words];
	logic [31:0] imem_off;
	logic [31:0] lcg_state;
	logic        check_done;
	int          check_errors;
	int          check_count;
	int          wait_cycles;

	mips_core i_mips_core (
		.clk        (clk),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata),
		.reg_we     (reg_we),
		.reg_waddr  (reg_waddr),
		.reg_wdata  (reg_wdata),
		.wb_pc      (wb_pc)
	);

	mips_checker i_checker (
		.clk        (clk),
		.reset      (reset),
		.prog       (prog),
		.dmem_init  (dmem_init),
		.imem_addr  (imem_addr),
		.reg_we     (reg_we),
		.reg_waddr  (reg_waddr),
		.reg_wdata  (reg_wdata),
		.wb_pc      (wb_pc),
		.dmem_we    (dmem_we),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.done       (check_done),
		.errors     (check_errors),
		.checks     (check_count)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	////////////////////////////////////////
	// Memories
	////////////////////////////////////////

	// Outside the program the core fetches nops
	always_comb begin
		imem_off   = imem_addr - mips_pkg::reset_pc;
		imem_rdata = 32'd0;
		if (imem_off < 32'(4 * prog_len)) begin
			imem_rdata = prog[imem_off[9:2]];
		end
	end

	assign dmem_rdata = dmem[dmem_addr[7:2]];

	always @(posedge clk) begin
		if (reset) begin
			dmem <= dmem_init;
		end else if (dmem_we) begin
			dmem[dmem_addr[7:2]] <= dmem_wdata;
		end
	end

	////////////////////////////////////////
	// Random program
	////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic int rand_below(input int range);
		lcg_state = lcg_next(lcg_state);
		return int'(lcg_state[30:16]) % range;
	endfunction

	function automatic logic [15:0] rand_half();
		lcg_state = lcg_next(lcg_state);
		return lcg_state[31:16];
	endfunction

	task automatic gen_program;
		logic [7:0] idx;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		int         kind;
		int         off;
		bit         last_beq;
		last_beq = 1'b0;
		for (idx = 8'd0; idx < 8'(prog_len - 2); idx++) begin
			rs   = 5'(rand_below(8));
			rt   = 5'(rand_below(8));
			rd   = 5'(rand_below(8));
			kind = rand_below(7);
			// No beq in a delay slot, none whose slot is the final loop
			if (kind == 6 && (last_beq || int'(idx) > prog_len - 4)) begin
				kind = 0;
			end
			case (kind)
				0: prog[idx] = {mips_pkg::op_special, rs, rt, rd, 5'd0, mips_pkg::fn_addu};
				1: prog[idx] = {mips_pkg::op_special, rs, rt, rd, 5'd0, mips_pkg::fn_subu};
				2: prog[idx] = {mips_pkg::op_ori, rs, rt, rand_half()};
				3: prog[idx] = {mips_pkg::op_lui, 5'd0, rt, rand_half()};
				4: prog[idx] = {mips_pkg::op_lw, 5'd0, rt, 16'(rand_below(dmem_words) * 4)};
				5: prog[idx] = {mips_pkg::op_sw, 5'd0, rt, 16'(rand_below(dmem_words) * 4)};
				default: begin
					off = 1 + rand_below(4);
					if (int'(idx) + 1 + off > prog_len - 2) begin
						off = prog_len - 3 - int'(idx);
					end
					prog[idx] = {mips_pkg::op_beq, rs, rt, 16'(off)};
				end
			endcase
			last_beq = (kind == 6);
		end
		// Self loop with a nop in its delay slot
		prog[prog_len - 2] = {mips_pkg::op_beq, 5'd0, 5'd0, 16'hffff};
		prog[prog_len - 1] = 32'd0;
	endtask

	task automatic fill_dmem;
		logic [6:0] w;
		for (w = 7'd0; w < 7'(dmem_words); w++) begin
			dmem_init[w[5:0]] = {10'h2a5, w[5:0], 10'h155, ~w[5:0]};
		end
	endtask

	////////////////////////////////////////
	// Run control
	////////////////////////////////////////

	initial begin
		reset <= 1'b1;
		lcg_state = 32'd46;
		gen_program();
		fill_dmem();
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		wait_cycles = 0;
		while (!check_done && wait_cycles < max_cycles + 200) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (!check_done) begin
			$display("Timeout, the checker did not finish within %0d cycles", wait_cycles);
			$display("*** TEST FAILED ***");
		end else begin
			$display("Checks: %0d, errors: %0d", check_count, check_errors);
			if (check_errors == 0) begin
				$display("*** TEST PASSED ***");
			end else begin
				$display("*** TEST FAILED ***");
			end
		end
		$finish;
	end

endmodule

//--- bench/mips_props.sv
`timescale 1ns/1ps

module mips_props (
	input logic        clk,
	input logic        reset,
	input logic [31:0] imem_addr,
	input logic        dmem_we,
	input logic        reg_we,
	input logic [4:0]  reg_waddr,
	input logic        stall
);

	// Register 0 is never a write target
	no_write_r0: assert property (@(posedge clk) disable iff (reset)
		!(reg_we && reg_waddr == 5'd0))
		else $error("register write to r0");

	no_store_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !dmem_we)
		else $error("data memory write while reset is high");

	fetch_aligned: assert property (@(posedge clk) disable iff (reset)
		imem_addr[1:0] == 2'b00)
		else $error("fetch address %h is not word aligned", imem_addr);

	// A stall fetches the same word again
	fetch_hold: assert property (@(posedge clk) disable iff (reset)
		$past(stall) |-> imem_addr == $past(imem_addr))
		else $error("fetch address %h changed across a stall", imem_addr);

endmodule

bind mips_core mips_props i_mips_props (
	.clk       (clk),
	.reset     (reset),
	.imem_addr (imem_addr),
	.dmem_we   (dmem_we),
	.reg_we    (reg_we),
	.reg_waddr (reg_waddr),
	.stall     (stall)
);

//--- bench/mips_checker.sv
`timescale 1ns/1ps

module mips_checker (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] prog [200],
	input  logic [31:0] dmem_init [64],
	input  logic [31:0] imem_addr,
	input  logic        reg_we,
	input  logic [4:0]  reg_waddr,
	input  logic [31:0] reg_wdata,
	input  logic [31:0] wb_pc,
	input  logic        dmem_we,
	input  logic [31:0] dmem_addr,
	input  logic [31:0] dmem_wdata,
	output logic        done,
	output int          errors,
	output int          checks
);

	localparam int prog_len   = 200;
	localparam int max_cycles = 3000;
	localparam logic [31:0] loop_pc = mips_pkg::reset_pc + 32'(4 * (prog_len - 2));

	logic [4:0]  exp_waddr [$];
	logic [31:0] exp_wdata [$];
	logic [31:0] exp_wpc [$];
	logic [31:0] exp_saddr [$];
	logic [31:0] exp_sdata [$];
	int          err_reset;
	int          err_write;
	int          err_store;
	int          err_pc;
	int          err_done;

	////////////////////////////////////////
	// Instruction-level model
	////////////////////////////////////////

	task automatic build_expected;
		logic [31:0] regs [32];
		logic [31:0] mem [64];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] sext;
		logic [31:0] addr;
		logic [7:0]  pc;
		logic [7:0]  npc;
		logic [7:0]  nxt;
		logic [4:0]  dst;
		bit          wr;
		int          steps;
		regs  = '{default: 32'd0};
		mem   = dmem_init;
		pc    = 8'd0;
		npc   = 8'd1;
		steps = 0;
		// Stops when the self loop is fetched
		while (pc != 8'(prog_len - 2) && steps < 1000) begin
			w    = prog[pc];
			a    = regs[w[25:21]];
			b    = regs[w[20:16]];
			sext = {{16{w[15]}}, w[15:0]};
			addr = a + sext;
			nxt  = npc + 8'd1;
			wr   = 1'b0;
			dst  = w[20:16];
			res  = 32'd0;
			case (w[31:26])
				mips_pkg::op_special: begin
					dst = w[15:11];
					if (w[5:0] == mips_pkg::fn_addu) begin
						res = a + b;
						wr  = 1'b1;
					end else if (w[5:0] == mips_pkg::fn_subu) begin
						res = a - b;
						wr  = 1'b1;
					end
				end
				mips_pkg::op_ori: begin
					res = a | {16'h0000, w[15:0]};
					wr  = 1'b1;
				end
				mips_pkg::op_lui: begin
					res = {w[15:0], 16'h0000};
					wr  = 1'b1;
				end
				mips_pkg::op_lw: begin
					res = mem[addr[7:2]];
					wr  = 1'b1;
				end
				mips_pkg::op_sw: begin
					exp_saddr.push_back(addr);
					exp_sdata.push_back(b);
					mem[addr[7:2]] = b;
				end
				mips_pkg::op_beq: begin
					// Target counted from the delay slot
					if (a == b) begin
						nxt = npc + w[7:0];
					end
				end
				default: begin
					wr = 1'b0;
				end
			endcase
			if (wr && dst != 5'd0) begin
				regs[dst] = res;
				exp_waddr.push_back(dst);
				exp_wdata.push_back(res);
				exp_wpc.push_back(mips_pkg::reset_pc + {22'd0, pc, 2'b00});
			end
			pc    = npc;
			npc   = nxt;
			steps++;
		end
	endtask

	////////////////////////////////////////
	// Comparison
	////////////////////////////////////////

	function automatic bit values_match(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		if (got !== want) begin
			$display("FAIL %s: got %h, expected %h at %0t", name, got, want, $time);
			return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic check_write;
		if (exp_waddr.size() == 0) begin
			$display("Unexpected register write to r%0d from pc %h", reg_waddr, wb_pc);
			err_done++;
		end else begin
			if (!values_match("reg_waddr", 32'(reg_waddr), 32'(exp_waddr[0]))) err_write++;
			if (!values_match("reg_wdata", reg_wdata, exp_wdata[0])) err_write++;
			if (!values_match("wb_pc", wb_pc, exp_wpc[0])) err_pc++;
			void'(exp_waddr.pop_front());
			void'(exp_wdata.pop_front());
			void'(exp_wpc.pop_front());
		end
	endtask

	task automatic check_store;
		if (exp_saddr.size() == 0) begin
			$display("Unexpected store of %h to address %h", dmem_wdata, dmem_addr);
			err_done++;
		end else begin
			if (!values_match("dmem_addr", dmem_addr, exp_saddr[0])) err_store++;
			if (!values_match("dmem_wdata", dmem_wdata, exp_sdata[0])) err_store++;
			void'(exp_saddr.pop_front());
			void'(exp_sdata.pop_front());
		end
	endtask

	// Outputs sampled on the falling edge, away from register updates
	initial begin : watch
		int cyc;
		int drain;
		bit loop_seen;
		bit released;
		done      = 1'b0;
		errors    = 0;
		checks    = 0;
		err_reset = 0;
		err_write = 0;
		err_store = 0;
		err_pc    = 0;
		err_done  = 0;
		released  = 1'b0;
		cyc       = 0;
		while (!released && cyc < 50) begin
			@(negedge clk);
			cyc++;
			released = !reset;
		end
		if (!released) begin
			$display("Reset was never released, no instruction checks were run");
			err_done++;
		end else begin
			if (!values_match("reg_we", 32'(reg_we), 32'd0)) err_reset++;
			if (!values_match("dmem_we", 32'(dmem_we), 32'd0)) err_reset++;
			if (!values_match("imem_addr", imem_addr, mips_pkg::reset_pc)) err_reset++;
			$display("Reset state: %0d errors", err_reset);
			build_expected();
			cyc       = 0;
			drain     = 0;
			loop_seen = 1'b0;
			// A few idle cycles after the loop catch stray writes
			while (drain < 8 && cyc < max_cycles) begin
				@(negedge clk);
				cyc++;
				if (reg_we) check_write();
				if (dmem_we) check_store();
				if (imem_addr == loop_pc) loop_seen = 1'b1;
				if (loop_seen && exp_waddr.size() == 0 && exp_saddr.size() == 0) drain++;
			end
			if (drain < 8) begin
				$display("Timeout after %0d cycles: loop reached %0d, %0d writes and %0d stores missing",
					cyc, loop_seen, exp_waddr.size(), exp_saddr.size());
				err_done++;
			end
			$display("Register writes: %0d errors", err_write);
			$display("Stores: %0d errors", err_store);
			$display("Control flow: %0d errors", err_pc);
		end
		$display("Completion: %0d errors", err_done);
		errors = err_reset + err_write + err_store + err_pc + err_done;
		done   = 1'b1;
	end

endmodule

//--- design/mips_core.sv
`timescale 1ns/1ps

module mips_core (
	input  logic        clk,
	input  logic        reset,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_rdata,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	output logic        dmem_we,
	input  logic [31:0] dmem_rdata,
	output logic        reg_we,
	output logic [4:0]  reg_waddr,
	output logic [31:0] reg_wdata,
	output logic [31:0] wb_pc
);

	// Fetch
	logic [31:0]        pc4_f;
	logic               stall;
	logic               branch_taken;
	logic [31:0]        branch_target;

	// Decode
	logic [31:0]        instr_d;
	logic [31:0]        pc4_d;
	logic [4:0]         rs_d;
	logic [4:0]         rt_d;
	logic [4:0]         a3_d;
	logic [31:0]        ext_d;
	logic               is_branch_d;
	logic               uses_rs_d;
	logic               uses_rt_d;
	logic [31:0]        rdata1;
	logic [31:0]        rdata2;
	logic [31:0]        v1_d;
	logic [31:0]        v2_d;
	mips_pkg::fwd_sel_e fwd_a_d;
	mips_pkg::fwd_sel_e fwd_b_d;

	// Execute
	logic [31:0]        instr_e;
	logic [31:0]        v1_e;
	logic [31:0]        v2_e;
	logic [31:0]        ext_e;
	logic [31:0]        pc4_e;
	logic [4:0]         a3_e;
	logic [4:0]         rs_e;
	logic [4:0]         rt_e;
	mips_pkg::alu_op_e  alu_fn_e;
	logic               alu_src_imm_e;
	logic               mem_read_e;
	mips_pkg::fwd_sel_e fwd_a_e;
	mips_pkg::fwd_sel_e fwd_b_e;
	logic [31:0]        a_e;
	logic [31:0]        b_fwd_e;
	logic [31:0]        b_e;
	logic [31:0]        alu_c_e;

	// Memory
	logic [31:0]        instr_m;
	logic [31:0]        v2_m;
	logic [31:0]        alu_c_m;
	logic [31:0]        pc4_m;
	logic [4:0]         a3_m;
	logic               mem_read_m;
	logic               mem_write_m;

	// Writeback
	logic [31:0]        instr_w;
	logic [31:0]        pc4_w;
	logic [31:0]        alu_c_w;
	logic [31:0]        dm_rd_w;
	logic [4:0]         a3_w;

	////////////////////////////////////////
	// Fetch
	////////////////////////////////////////

	fetch_unit i_fetch_unit (
		.clk           (clk),
		.reset         (reset),
		.en            (!stall),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.pc            (imem_addr)
	);

	assign pc4_f = imem_addr + 32'd4;

	reg_d i_reg_d (
		.clk     (clk),
		.reset   (reset),
		.en      (!stall),
		.instr   (imem_rdata),
		.pc4     (pc4_f),
		.instr_d (instr_d),
		.pc4_d   (pc4_d)
	);

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	decoder i_dec_d (
		.instr       (instr_d),
		.rs          (rs_d),
		.rt          (rt_d),
		.a3          (a3_d),
		.ext         (ext_d),
		.alu_op      (),
		.alu_src_imm (),
		.mem_read    (),
		.mem_write   (),
		.is_branch   (is_branch_d),
		.uses_rs     (uses_rs_d),
		.uses_rt     (uses_rt_d)
	);

	reg_file i_reg_file (
		.clk    (clk),
		.reset  (reset),
		.we     (reg_we),
		.waddr  (a3_w),
		.raddr1 (rs_d),
		.raddr2 (rt_d),
		.wdata  (reg_wdata),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	hazard_unit i_hazard_unit (
		.rs_d        (rs_d),
		.rt_d        (rt_d),
		.rs_e        (rs_e),
		.rt_e        (rt_e),
		.a3_e        (a3_e),
		.a3_m        (a3_m),
		.a3_w        (a3_w),
		.uses_rs_d   (uses_rs_d),
		.uses_rt_d   (uses_rt_d),
		.is_branch_d (is_branch_d),
		.mem_read_e  (mem_read_e),
		.mem_read_m  (mem_read_m),
		.stall       (stall),
		.fwd_a_d     (fwd_a_d),
		.fwd_b_d     (fwd_b_d),
		.fwd_a_e     (fwd_a_e),
		.fwd_b_e     (fwd_b_e)
	);

	assign v1_d = (fwd_a_d == mips_pkg::fwd_mem) ? alu_c_m : rdata1;
	assign v2_d = (fwd_b_d == mips_pkg::fwd_mem) ? alu_c_m : rdata2;

	// Target counted from the delay slot
	assign branch_taken  = is_branch_d && (v1_d == v2_d);
	assign branch_target = pc4_d + {ext_d[29:0], 2'b00};

	reg_e i_reg_e (
		.clk     (clk),
		.reset   (reset),
		.clr     (stall),
		.instr   (instr_d),
		.v1      (v1_d),
		.v2      (v2_d),
		.ext     (ext_d),
		.pc4     (pc4_d),
		.a3      (a3_d),
		.instr_e (instr_e),
		.v1_e    (v1_e),
		.v2_e    (v2_e),
		.ext_e   (ext_e),
		.pc4_e   (pc4_e),
		.a3_e    (a3_e)
	);

	////////////////////////////////////////
	// Execute
	////////////////////////////////////////

	decoder i_dec_e (
		.instr       (instr_e),
		.rs          (rs_e),
		.rt          (rt_e),
		.a3          (),
		.ext         (),
		.alu_op      (alu_fn_e),
		.alu_src_imm (alu_src_imm_e),
		.mem_read    (mem_read_e),
		.mem_write   (),
		.is_branch   (),
		.uses_rs     (),
		.uses_rt     ()
	);

	always_comb begin
		case (fwd_a_e)
			mips_pkg::fwd_mem: a_e = alu_c_m;
			mips_pkg::fwd_wb:  a_e = reg_wdata;
			default:           a_e = v1_e;
		endcase
	end

	always_comb begin
		case (fwd_b_e)
			mips_pkg::fwd_mem: b_fwd_e = alu_c_m;
			mips_pkg::fwd_wb:  b_fwd_e = reg_wdata;
			default:           b_fwd_e = v2_e;
		endcase
	end

	assign b_e = alu_src_imm_e ? ext_e : b_fwd_e;

	alu i_alu (
		.a  (a_e),
		.b  (b_e),
		.op (alu_fn_e),
		.y  (alu_c_e)
	);

	reg_m i_reg_m (
		.clk     (clk),
		.reset   (reset),
		.instr   (instr_e),
		.v2      (b_fwd_e),
		.alu_c   (alu_c_e),
		.pc4     (pc4_e),
		.a3      (a3_e),
		.instr_m (instr_m),
		.v2_m    (v2_m),
		.alu_c_m (alu_c_m),
		.pc4_m   (pc4_m),
		.a3_m    (a3_m)
	);

	////////////////////////////////////////
	// Memory
	////////////////////////////////////////

	decoder i_dec_m (
		.instr       (instr_m),
		.rs          (),
		.rt          (),
		.a3          (),
		.ext         (),
		.alu_op      (),
		.alu_src_imm (),
		.mem_read    (mem_read_m),
		.mem_write   (mem_write_m),
		.is_branch   (),
		.uses_rs     (),
		.uses_rt     ()
	);

	assign dmem_addr  = alu_c_m;
	assign dmem_wdata = v2_m;
	assign dmem_we    = mem_write_m;

	reg_w i_reg_w (
		.clk     (clk),
		.reset   (reset),
		.instr   (instr_m),
		.pc4     (pc4_m),
		.alu_c   (alu_c_m),
		.dm_rd   (dmem_rdata),
		.a3      (a3_m),
		.instr_w (instr_w),
		.pc4_w   (pc4_w),
		.alu_c_w (alu_c_w),
		.dm_rd_w (dm_rd_w),
		.a3_w    (a3_w)
	);

	////////////////////////////////////////
	// Writeback
	////////////////////////////////////////

	// Non-writing instructions carry a3 of zero
	assign reg_we    = (a3_w != 5'd0);
	assign reg_waddr = a3_w;
	assign reg_wdata = (instr_w[31:26] == mips_pkg::op_lw) ? dm_rd_w : alu_c_w;
	assign wb_pc     = pc4_w - 32'd4;

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	input  mips_pkg::alu_op_e op,
	output logic [31:0]       y
);

	always_comb begin
		case (op)
			mips_pkg::alu_add: y = a + b;
			mips_pkg::alu_sub: y = a - b;
			mips_pkg::alu_or:  y = a | b;
			// Immediate arrives zero extended in b
			mips_pkg::alu_lui: y = {b[15:0], 16'h0000};
			default:           y = a + b;
		endcase
	end

endmodule

//--- design/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	input  logic [4:0]         rs_d,
	input  logic [4:0]         rt_d,
	input  logic [4:0]         rs_e,
	input  logic [4:0]         rt_e,
	input  logic [4:0]         a3_e,
	input  logic [4:0]         a3_m,
	input  logic [4:0]         a3_w,
	input  logic               uses_rs_d,
	input  logic               uses_rt_d,
	input  logic               is_branch_d,
	input  logic               mem_read_e,
	input  logic               mem_read_m,
	output logic               stall,
	output mips_pkg::fwd_sel_e fwd_a_d,
	output mips_pkg::fwd_sel_e fwd_b_d,
	output mips_pkg::fwd_sel_e fwd_a_e,
	output mips_pkg::fwd_sel_e fwd_b_e
);

	logic rs_in_e;
	logic rt_in_e;
	logic rs_in_m;
	logic rt_in_m;
	logic load_use;
	logic branch_wait;

	// Decode sources matching a live destination further down
	assign rs_in_e = uses_rs_d && (a3_e != 5'd0) && (rs_d == a3_e);
	assign rt_in_e = uses_rt_d && (a3_e != 5'd0) && (rt_d == a3_e);
	assign rs_in_m = uses_rs_d && (a3_m != 5'd0) && (rs_d == a3_m);
	assign rt_in_m = uses_rt_d && (a3_m != 5'd0) && (rt_d == a3_m);

	////////////////////////////////////////
	// Stall
	////////////////////////////////////////

	// Load data appears only after the memory stage
	assign load_use = mem_read_e && (rs_in_e || rt_in_e);

	// Branch compares in decode, results still in execute come too late
	assign branch_wait = is_branch_d &&
		(rs_in_e || rt_in_e || (mem_read_m && (rs_in_m || rt_in_m)));

	assign stall = load_use || branch_wait;

	////////////////////////////////////////
	// Forwarding
	////////////////////////////////////////

	// Writeback reaches decode through the register file
	always_comb begin
		fwd_a_d = mips_pkg::fwd_none;
		fwd_b_d = mips_pkg::fwd_none;
		if (rs_in_m && !mem_read_m) begin
			fwd_a_d = mips_pkg::fwd_mem;
		end
		if (rt_in_m && !mem_read_m) begin
			fwd_b_d = mips_pkg::fwd_mem;
		end
	end

	// Memory holds the younger result
	always_comb begin
		fwd_a_e = mips_pkg::fwd_none;
		fwd_b_e = mips_pkg::fwd_none;
		if (a3_m != 5'd0 && rs_e == a3_m) begin
			fwd_a_e = mips_pkg::fwd_mem;
		end else if (a3_w != 5'd0 && rs_e == a3_w) begin
			fwd_a_e = mips_pkg::fwd_wb;
		end
		if (a3_m != 5'd0 && rt_e == a3_m) begin
			fwd_b_e = mips_pkg::fwd_mem;
		end else if (a3_w != 5'd0 && rt_e == a3_w) begin
			fwd_b_e = mips_pkg::fwd_wb;
		end
	end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic        clk,
	input  logic        reset,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [4:0]  raddr1,
	input  logic [4:0]  raddr2,
	input  logic [31:0] wdata,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	logic [31:0] regs [32];
	logic        wr_live;

	// Register 0 never takes a write, so it stays zero after reset
	assign wr_live = we && (waddr != 5'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wr_live) begin
			regs[waddr] <= wdata;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	assign rdata1 = (wr_live && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (wr_live && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

//--- design/decoder.sv
`timescale 1ns/1ps

module decoder (
	input  logic [31:0]       instr,
	output logic [4:0]        rs,
	output logic [4:0]        rt,
	output logic [4:0]        a3,
	output logic [31:0]       ext,
	output mips_pkg::alu_op_e alu_op,
	output logic              alu_src_imm,
	output logic              mem_read,
	output logic              mem_write,
	output logic              is_branch,
	output logic              uses_rs,
	output logic              uses_rt
);

	mips_pkg::opcode_e opcode;
	mips_pkg::funct_e  funct;
	logic [4:0]        rd;
	logic              zero_ext;

	assign opcode = mips_pkg::opcode_e'(instr[31:26]);
	assign funct  = mips_pkg::funct_e'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	// Logical immediates zero extend, offsets sign extend
	assign zero_ext = (opcode == mips_pkg::op_ori) || (opcode == mips_pkg::op_lui);
	assign ext      = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	always_comb begin
		a3          = 5'd0;
		alu_op      = mips_pkg::alu_add;
		alu_src_imm = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		is_branch   = 1'b0;
		uses_rs     = 1'b0;
		uses_rt     = 1'b0;
		case (opcode)
			mips_pkg::op_special: begin
				a3      = rd;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				if (funct == mips_pkg::fn_subu) begin
					alu_op = mips_pkg::alu_sub;
				end
			end
			mips_pkg::op_ori: begin
				a3          = rt;
				alu_op      = mips_pkg::alu_or;
				alu_src_imm = 1'b1;
				uses_rs     = 1'b1;
			end
			mips_pkg::op_lui: begin
				a3          = rt;
				alu_op      = mips_pkg::alu_lui;
				alu_src_imm = 1'b1;
			end
			mips_pkg::op_lw: begin
				a3          = rt;
				alu_src_imm = 1'b1;
				mem_read    = 1'b1;
				uses_rs     = 1'b1;
			end
			mips_pkg::op_sw: begin
				alu_src_imm = 1'b1;
				mem_write   = 1'b1;
				uses_rs     = 1'b1;
				uses_rt     = 1'b1;
			end
			mips_pkg::op_beq: begin
				is_branch = 1'b1;
				uses_rs   = 1'b1;
				uses_rt   = 1'b1;
			end
			default: begin
				a3 = 5'd0;
			end
		endcase
	end

endmodule

//--- design/stage_regs.sv
`timescale 1ns/1ps

////////////////////////////////////////
// Fetch to decode
////////////////////////////////////////

module reg_d (
	input  logic        clk,
	input  logic        reset,
	input  logic        en,
	input  logic [31:0] instr,
	input  logic [31:0] pc4,
	output logic [31:0] instr_d,
	output logic [31:0] pc4_d
);

	// Held while a hazard keeps the instruction in decode
	always_ff @(posedge clk) begin
		if (reset) begin
			instr_d <= 32'd0;
			pc4_d   <= 32'd0;
		end else if (en) begin
			instr_d <= instr;
			pc4_d   <= pc4;
		end
	end

endmodule

////////////////////////////////////////
// Decode to execute
////////////////////////////////////////

module reg_e (
	input  logic        clk,
	input  logic        reset,
	input  logic        clr,
	input  logic [31:0] instr,
	input  logic [31:0] v1,
	input  logic [31:0] v2,
	input  logic [31:0] ext,
	input  logic [31:0] pc4,
	input  logic [4:0]  a3,
	output logic [31:0] instr_e,
	output logic [31:0] v1_e,
	output logic [31:0] v2_e,
	output logic [31:0] ext_e,
	output logic [31:0] pc4_e,
	output logic [4:0]  a3_e
);

	// Clear inserts a nop bubble
	always_ff @(posedge clk) begin
		if (reset || clr) begin
			instr_e <= 32'd0;
			v1_e    <= 32'd0;
			v2_e    <= 32'd0;
			ext_e   <= 32'd0;
			pc4_e   <= 32'd0;
			a3_e    <= 5'd0;
		end else begin
			instr_e <= instr;
			v1_e    <= v1;
			v2_e    <= v2;
			ext_e   <= ext;
			pc4_e   <= pc4;
			a3_e    <= a3;
		end
	end

endmodule

////////////////////////////////////////
// Execute to memory
////////////////////////////////////////

module reg_m (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] instr,
	input  logic [31:0] v2,
	input  logic [31:0] alu_c,
	input  logic [31:0] pc4,
	input  logic [4:0]  a3,
	output logic [31:0] instr_m,
	output logic [31:0] v2_m,
	output logic [31:0] alu_c_m,
	output logic [31:0] pc4_m,
	output logic [4:0]  a3_m
);

	always_ff @(posedge clk) begin
		if (reset) begin
			instr_m <= 32'd0;
			v2_m    <= 32'd0;
			alu_c_m <= 32'd0;
			pc4_m   <= 32'd0;
			a3_m    <= 5'd0;
		end else begin
			instr_m <= instr;
			v2_m    <= v2;
			alu_c_m <= alu_c;
			pc4_m   <= pc4;
			a3_m    <= a3;
		end
	end

endmodule

////////////////////////////////////////
// Memory to writeback
////////////////////////////////////////

module reg_w (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] instr,
	input  logic [31:0] pc4,
	input  logic [31:0] alu_c,
	input  logic [31:0] dm_rd,
	input  logic [4:0]  a3,
	output logic [31:0] instr_w,
	output logic [31:0] pc4_w,
	output logic [31:0] alu_c_w,
	output logic [31:0] dm_rd_w,
	output logic [4:0]  a3_w
);

	always_ff @(posedge clk) begin
		if (reset) begin
			instr_w <= 32'd0;
			pc4_w   <= 32'd0;
			alu_c_w <= 32'd0;
			dm_rd_w <= 32'd0;
			a3_w    <= 5'd0;
		end else begin
			instr_w <= instr;
			pc4_w   <= pc4;
			alu_c_w <= alu_c;
			dm_rd_w <= dm_rd;
			a3_w    <= a3;
		end
	end

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic        clk,
	input  logic        reset,
	input  logic        en,
	input  logic        branch_taken,
	input  logic [31:0] branch_target,
	output logic [31:0] pc
);

	logic [31:0] pc_next;

	// Branch resolved in decode redirects the word after the delay slot
	assign pc_next = branch_taken ? branch_target : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= mips_pkg::reset_pc;
		end else if (en) begin
			pc <= pc_next;
		end
	end

endmodule

//--- design/mips_pkg.sv
package mips_pkg;

	////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_beq     = 6'h04,
		op_ori     = 6'h0d,
		op_lui     = 6'h0f,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} opcode_e;

	// Funct field of special instructions, instr[5:0]
	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23
	} funct_e;

	////////////////////////////////////////
	// Datapath controls
	////////////////////////////////////////

	typedef enum logic [1:0] {
		alu_add,
		alu_sub,
		alu_or,
		alu_lui
	} alu_op_e;

	// Operand source for forwarding muxes
	typedef enum logic [1:0] {
		fwd_none,
		fwd_mem,
		fwd_wb
	} fwd_sel_e;

	localparam logic [31:0] reset_pc = 32'h0000_3000;

endpackage
